// File: hw/lease_pkg.sv
package lease_pkg;

	// field widths
	// --------------------
	localparam int BW_LEASE    = 8;           // lease register width
	localparam int BW_REF_ADDR = 24;          // word address width
	localparam int WB_DW       = 32;          // wishbone data width
	localparam int WB_AW       = 8;           // wishbone address width

	// wishbone regions, top two address bits
	localparam logic [1:0] REGION_CONFIG = 2'd0;  // default lease at index 0
	localparam logic [1:0] REGION_ENTRY  = 2'd1;  // table entry write
	localparam logic [1:0] REGION_REMOVE = 2'd2;  // table entry clear

	// data word views
	// --------------------
	typedef struct packed {
		logic [WB_DW-BW_LEASE-1:0] reserved;  // reads back as zero
		logic [BW_LEASE-1:0]       default_lease;
	} lease_cfg_t;

	typedef struct packed {
		logic [BW_REF_ADDR-1:0] ref_addr;     // word address to match
		logic [BW_LEASE-1:0]    lease;        // lease given on a match
	} lease_entry_t;

	// one bus word, read as config or as table entry depending on region
	typedef union packed {
		lease_cfg_t   cfg;
		lease_entry_t entry;
	} lease_wb_word_u;

	// cache side
	// --------------------
	typedef struct packed {
		logic                   hit;          // one cycle strobe
		logic                   miss;         // one cycle strobe
		logic [BW_REF_ADDR-1:0] addr;         // search address of the access
	} lease_req_t;

	typedef struct packed {
		logic done;                           // replacement line valid on addr_o
		logic expired;                        // chosen line had a zero lease
		logic dflt;                           // hit renewed with the default lease
	} lease_resp_t;

endpackage

// File: hw/lease_lookup_table.sv
`timescale 1ns/1ps

module lease_lookup_table import lease_pkg::*; #(
	parameter int N_ENTRIES = 8
)(
	input  logic                   clock_i,
	input  logic                   resetn_i,
	input  logic                   wr_i,          // write entry_i at idx_i
	input  logic                   rm_i,          // invalidate entry at idx_i
	input  logic [BW_ENTRIES-1:0]  idx_i,
	input  lease_entry_t           entry_i,
	input  logic [BW_REF_ADDR-1:0] search_addr_i,
	output logic                   hit_o,         // some valid entry matched
	output logic [BW_LEASE-1:0]    lease_o        // lease of lowest match
);

	localparam int BW_ENTRIES = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;

	lease_entry_t             entries_q [N_ENTRIES];   // payload, no reset
	logic [N_ENTRIES-1:0]     valid_q;

	// table writes
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q <= '0;
		end else begin
			if (wr_i) begin
				entries_q[idx_i] <= entry_i;
				valid_q[idx_i]   <= 1'b1;
			end
			if (rm_i)
				valid_q[idx_i] <= 1'b0;  // clear wins over a same cycle write
		end
	end

	// search, walk downwards so the lowest index is left standing
	always_comb begin
		hit_o   = 1'b0;
		lease_o = '0;
		for (int i = N_ENTRIES - 1; i >= 0; i--) begin
			if (valid_q[i] && (entries_q[i].ref_addr == search_addr_i)) begin
				hit_o   = 1'b1;
				lease_o = entries_q[i].lease;
			end
		end
	end

endmodule

// File: hw/expired_line_encoder.sv
`timescale 1ns/1ps

module expired_line_encoder import lease_pkg::*; #(
	parameter int CACHE_BLOCK_CAPACITY = 4
)(
	input  logic [CACHE_BLOCK_CAPACITY*BW_LEASE-1:0] leases_i,  // line 0 in the low bits
	output logic                                     any_o,     // at least one lease at zero
	output logic [BW_CAPACITY-1:0]                   index_o    // lowest zero lease line
);

	localparam int BW_CAPACITY = $clog2(CACHE_BLOCK_CAPACITY);

	logic [CACHE_BLOCK_CAPACITY-1:0] expired_flags;

	for (genvar k = 0; k < CACHE_BLOCK_CAPACITY; k++) begin : g_flag
		assign expired_flags[k] = ~|leases_i[k*BW_LEASE +: BW_LEASE];
	end

	assign any_o = |expired_flags;

	// priority encoder, low index wins
	always_comb begin
		index_o = '0;
		for (int i = CACHE_BLOCK_CAPACITY - 1; i >= 0; i--)
			if (expired_flags[i]) index_o = BW_CAPACITY'(i);
	end

endmodule

// File: hw/replacement_lfsr.sv
`timescale 1ns/1ps

module replacement_lfsr (
	input  logic       clock_i,
	input  logic       resetn_i,
	input  logic       enable_i,    // step once
	output logic [8:0] value_o
);

	logic [8:0] lfsr_q;

	// fibonacci form, taps 9 and 5
	// --------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			lfsr_q <= 9'h1FF;                          // any nonzero seed
		else if (enable_i)
			lfsr_q <= {lfsr_q[7:0], lfsr_q[8] ^ lfsr_q[4]};
	end

	assign value_o = lfsr_q;

endmodule

// File: hw/lease_config_wb.sv
`timescale 1ns/1ps

module lease_config_wb import lease_pkg::*; #(
	parameter int N_ENTRIES = 8
)(
	input  logic                  clock_i,
	input  logic                  resetn_i,

	// wishbone classic slave
	input  logic                  wb_cyc_i,
	input  logic                  wb_stb_i,
	input  logic                  wb_we_i,
	input  logic [WB_AW-1:0]      wb_adr_i,
	input  lease_wb_word_u        wb_dat_i,
	output lease_wb_word_u        wb_dat_o,
	output logic                  wb_ack_o,

	// to the controller
	output logic                  tbl_wr_o,        // one cycle
	output logic                  tbl_rm_o,        // one cycle
	output logic [BW_ENTRIES-1:0] tbl_idx_o,
	output lease_entry_t          tbl_entry_o,
	output logic [BW_LEASE-1:0]   default_lease_o  // level
);

	localparam int BW_ENTRIES = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;

	logic [1:0]          region;
	logic                cfg_sel;        // config region, index 0
	logic                wr_access;      // write taking effect this cycle
	logic [BW_LEASE-1:0] default_lease_q;

	// address decode
	// --------------------
	assign region    = wb_adr_i[WB_AW-1 -: 2];
	assign tbl_idx_o = wb_adr_i[BW_ENTRIES-1:0];
	assign cfg_sel   = (region == REGION_CONFIG) && (tbl_idx_o == '0);
	assign wr_access = wb_ack_o & wb_cyc_i & wb_stb_i & wb_we_i;  // writes act on ack

	// ack one cycle after the request is seen, never two in a row
	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			wb_ack_o <= 1'b0;
		else
			wb_ack_o <= wb_cyc_i & wb_stb_i & ~wb_ack_o;
	end

	// default lease register
	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			default_lease_q <= '0;
		else if (wr_access && cfg_sel)
			default_lease_q <= wb_dat_i.cfg.default_lease;  // config view
	end

	assign default_lease_o = default_lease_q;

	// table strobes
	// --------------------
	assign tbl_wr_o    = wr_access && (region == REGION_ENTRY);
	assign tbl_rm_o    = wr_access && (region == REGION_REMOVE);
	assign tbl_entry_o = wb_dat_i.entry;                     // entry view

	// read back, only the config word is readable
	always_comb begin
		wb_dat_o = '0;
		if (cfg_sel && !wb_we_i)
			wb_dat_o.cfg.default_lease = default_lease_q;
	end

endmodule

// File: hw/lease_policy_controller.sv
`timescale 1ns/1ps

module lease_policy_controller import lease_pkg::*; #(
	parameter int CACHE_BLOCK_CAPACITY = 4,
	parameter int N_ENTRIES            = 8
)(
	input  logic                   clock_i,
	input  logic                   resetn_i,

	// table programming, from the wishbone slave
	input  logic                   tbl_wr_i,
	input  logic                   tbl_rm_i,
	input  logic [BW_ENTRIES-1:0]  tbl_idx_i,
	input  lease_entry_t           tbl_entry_i,
	input  logic [BW_LEASE-1:0]    default_lease_i,

	// cache side
	input  lease_req_t             req_i,
	input  logic [BW_CAPACITY-1:0] cache_addr_i,   // line that was hit
	output lease_resp_t            resp_o,
	output logic [BW_CAPACITY-1:0] addr_o          // replacement line, held
);

	localparam int BW_ENTRIES  = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
	localparam int BW_CAPACITY = $clog2(CACHE_BLOCK_CAPACITY);

	typedef enum logic {
		ST_NORMAL   = 1'b0,
		ST_GENERATE = 1'b1   // random pick, one extra cycle
	} state_e;

	// lease lookup table
	// --------------------
	logic                llt_hit;
	logic [BW_LEASE-1:0] llt_lease;

	lease_lookup_table #(
		.N_ENTRIES     (N_ENTRIES)
	) llt_inst (
		.clock_i       (clock_i),
		.resetn_i      (resetn_i),
		.wr_i          (tbl_wr_i),
		.rm_i          (tbl_rm_i),
		.idx_i         (tbl_idx_i),
		.entry_i       (tbl_entry_i),
		.search_addr_i (req_i.addr),
		.hit_o         (llt_hit),
		.lease_o       (llt_lease)
	);

	// lease registers and zero lease encoder
	// --------------------
	logic [BW_LEASE-1:0]                     lease_q [CACHE_BLOCK_CAPACITY];  // one per line
	logic [CACHE_BLOCK_CAPACITY*BW_LEASE-1:0] leases_flat;
	logic                                    any_expired;
	logic [BW_CAPACITY-1:0]                  expired_idx;

	for (genvar k = 0; k < CACHE_BLOCK_CAPACITY; k++) begin : g_flat
		assign leases_flat[k*BW_LEASE +: BW_LEASE] = lease_q[k];
	end

	expired_line_encoder #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY)
	) encoder_inst (
		.leases_i             (leases_flat),
		.any_o                (any_expired),
		.index_o              (expired_idx)
	);

	// backup policy source
	logic       lfsr_en;
	logic [8:0] lfsr_val;

	replacement_lfsr lfsr_inst (
		.clock_i  (clock_i),
		.resetn_i (resetn_i),
		.enable_i (lfsr_en),
		.value_o  (lfsr_val)
	);

	// controller
	// --------------------
	state_e                 state_q;
	logic [BW_CAPACITY:0]   fill_q;       // lines used since reset, msb set when full
	logic                   full;

	assign full    = fill_q[BW_CAPACITY];
	assign lfsr_en = (state_q == ST_GENERATE);  // step after the value is taken

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			for (int j = 0; j < CACHE_BLOCK_CAPACITY; j++)
				lease_q[j] <= '0;
			fill_q  <= '0;
			state_q <= ST_NORMAL;
			resp_o  <= '0;
			addr_o  <= '0;
		end else begin
			resp_o <= '0;                       // flags are pulses
			case (state_q)
				ST_NORMAL: begin
					if (req_i.hit) begin
						// renew the hit line, count the rest down to zero
						for (int j = 0; j < CACHE_BLOCK_CAPACITY; j++) begin
							if (BW_CAPACITY'(j) == cache_addr_i)
								lease_q[j] <= llt_hit ? llt_lease : default_lease_i;
							else if (lease_q[j] != '0)
								lease_q[j] <= lease_q[j] - 1'b1;
						end
						resp_o.dflt <= ~llt_hit;    // no table match
					end
					if (req_i.miss) begin
						if (!full) begin
							resp_o.done <= 1'b1;
							addr_o      <= fill_q[BW_CAPACITY-1:0];  // next empty line
							fill_q      <= fill_q + 1'b1;
						end else if (any_expired) begin
							resp_o.done    <= 1'b1;
							resp_o.expired <= 1'b1;
							addr_o         <= expired_idx;
						end else begin
							state_q <= ST_GENERATE;  // nothing expired
						end
					end
				end
				ST_GENERATE: begin
					// strobes ignored here
					resp_o.done <= 1'b1;
					addr_o      <= lfsr_val[BW_CAPACITY:1];
					state_q     <= ST_NORMAL;
				end
				default: state_q <= ST_NORMAL;
			endcase
		end
	end

endmodule

// File: hw/lease_cache_policy_top.sv
`timescale 1ns/1ps

module lease_cache_policy_top import lease_pkg::*; #(
	parameter int CACHE_BLOCK_CAPACITY = 4,
	parameter int N_ENTRIES            = 8
)(
	input  logic                   clock_i,
	input  logic                   resetn_i,

	// wishbone classic slave
	input  logic                   wb_cyc_i,
	input  logic                   wb_stb_i,
	input  logic                   wb_we_i,
	input  logic [WB_AW-1:0]       wb_adr_i,
	input  lease_wb_word_u         wb_dat_i,
	output lease_wb_word_u         wb_dat_o,
	output logic                   wb_ack_o,

	// cache side
	input  lease_req_t             cache_req_i,
	input  logic [BW_CAPACITY-1:0] cache_addr_i,
	output lease_resp_t            resp_o,
	output logic [BW_CAPACITY-1:0] addr_o
);

	localparam int BW_ENTRIES  = (N_ENTRIES > 1) ? $clog2(N_ENTRIES) : 1;
	localparam int BW_CAPACITY = $clog2(CACHE_BLOCK_CAPACITY);

	// slave to controller
	// --------------------
	logic                  tbl_wr;
	logic                  tbl_rm;
	logic [BW_ENTRIES-1:0] tbl_idx;
	lease_entry_t          tbl_entry;
	logic [BW_LEASE-1:0]   default_lease;

	lease_config_wb #(
		.N_ENTRIES       (N_ENTRIES)
	) config_wb_inst (
		.clock_i         (clock_i),
		.resetn_i        (resetn_i),
		.wb_cyc_i        (wb_cyc_i),
		.wb_stb_i        (wb_stb_i),
		.wb_we_i         (wb_we_i),
		.wb_adr_i        (wb_adr_i),
		.wb_dat_i        (wb_dat_i),
		.wb_dat_o        (wb_dat_o),
		.wb_ack_o        (wb_ack_o),
		.tbl_wr_o        (tbl_wr),
		.tbl_rm_o        (tbl_rm),
		.tbl_idx_o       (tbl_idx),
		.tbl_entry_o     (tbl_entry),
		.default_lease_o (default_lease)
	);

	lease_policy_controller #(
		.CACHE_BLOCK_CAPACITY (CACHE_BLOCK_CAPACITY),
		.N_ENTRIES            (N_ENTRIES)
	) controller_inst (
		.clock_i              (clock_i),
		.resetn_i             (resetn_i),
		.tbl_wr_i             (tbl_wr),
		.tbl_rm_i             (tbl_rm),
		.tbl_idx_i            (tbl_idx),
		.tbl_entry_i          (tbl_entry),
		.default_lease_i      (default_lease),
		.req_i                (cache_req_i),
		.cache_addr_i         (cache_addr_i),
		.resp_o               (resp_o),
		.addr_o               (addr_o)
	);

endmodule

// File: testbench/lease_policy_tb.sv
`timescale 1ns/1ps

module lease_policy_tb import lease_pkg::*; ();

	localparam int LINE_W      = 2;      // index width for 4 lines
	localparam int WAIT_LIMIT  = 20;     // cycles per wait loop
	localparam int RUN_LIMIT   = 100000; // whole run in ns

	logic                  clock;
	logic                  resetn;
	logic                  wb_cyc;
	logic                  wb_stb;
	logic                  wb_we;
	logic [WB_AW-1:0]      wb_adr;
	lease_wb_word_u        wb_dat_w;   // master to slave
	lease_wb_word_u        wb_dat_r;   // slave to master
	logic                  wb_ack;
	lease_req_t            cache_req;
	logic [LINE_W-1:0]     cache_addr;
	lease_resp_t           resp;
	logic [LINE_W-1:0]     addr_out;

	int mismatch_count = 0;
	int timeout_count  = 0;
	int other_count    = 0;   // file and format problems

	lease_cache_policy_top #(
		.CACHE_BLOCK_CAPACITY (4),
		.N_ENTRIES            (8)
	) lease_cache_policy_top_inst (
		.clock_i      (clock),
		.resetn_i     (resetn),
		.wb_cyc_i     (wb_cyc),
		.wb_stb_i     (wb_stb),
		.wb_we_i      (wb_we),
		.wb_adr_i     (wb_adr),
		.wb_dat_i     (wb_dat_w),
		.wb_dat_o     (wb_dat_r),
		.wb_ack_o     (wb_ack),
		.cache_req_i  (cache_req),
		.cache_addr_i (cache_addr),
		.resp_o       (resp),
		.addr_o       (addr_out)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;       // 4 ns period
	end

	// compare tasks
	// --------------------
	task automatic check_word(input string name, input lease_wb_word_u exp,
	                          input lease_wb_word_u act);
		if (act !== exp) begin
			$display("MISMATCH %s: expected %h, actual %h", name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic check_resp(input string name, input lease_resp_t exp, input lease_resp_t act);
		if (act !== exp) begin
			$display("MISMATCH %s: expected done/expired/dflt %b, actual %b", name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic check_addr(input string name, input logic [LINE_W-1:0] exp,
	                          input logic [LINE_W-1:0] act);
		if (act !== exp) begin
			$display("MISMATCH %s: expected line %0d, actual %0d", name, exp, act);
			mismatch_count++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
			mismatch_count++;
		end
	endtask

	// bus and strobe drivers called on a falling edge
	// --------------------
	task automatic wb_access(input string name, input logic we, input logic [WB_AW-1:0] adr,
	                         input lease_wb_word_u wdat, output lease_wb_word_u rdat);
		int waited;
		int acks;
		rdat     = '0;
		acks     = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		@(negedge clock);
		waited = 1;
		while (!wb_ack && waited < WAIT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (!wb_ack) begin
			$display("%s: no wishbone ack after %0d cycles", name, waited);
			timeout_count++;
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
		end else begin
			rdat = wb_dat_r;              // read data valid in the ack cycle
			acks = 1;
			@(negedge clock);             // write lands at the edge closing the ack cycle
			if (wb_ack) acks++;
			wb_cyc = 1'b0;
			wb_stb = 1'b0;
			wb_we  = 1'b0;
			@(negedge clock);
			if (wb_ack) acks++;
			check_count({name, " ack count"}, 1, acks);
		end
	endtask

	task automatic drive_hit(input string name, input logic [LINE_W-1:0] line,
	                         input logic [BW_REF_ADDR-1:0] addr, input logic exp_dflt);
		lease_resp_t exp;
		cache_req.hit  = 1'b1;
		cache_req.addr = addr;
		cache_addr     = line;
		@(negedge clock);                 // flag pulses in the cycle after the hit
		cache_req = '0;
		exp       = '0;
		exp.dflt  = exp_dflt;
		check_resp(name, exp, resp);
	endtask

	task automatic drive_miss(input string name, input logic [BW_REF_ADDR-1:0] addr,
	                          input logic [LINE_W-1:0] exp_line, input logic exp_expired,
	                          input int exp_delay);
		int          waited;
		lease_resp_t exp;
		cache_req.miss = 1'b1;
		cache_req.addr = addr;
		@(negedge clock);
		waited    = 1;
		cache_req = '0;
		while (!resp.done && waited < WAIT_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (!resp.done) begin
			$display("%s: no done after %0d cycles", name, waited);
			timeout_count++;
		end else begin
			exp         = '0;
			exp.done    = 1'b1;
			exp.expired = exp_expired;
			check_resp(name, exp, resp);
			check_addr(name, exp_line, addr_out);
			check_count({name, " done delay"}, exp_delay, waited);
		end
	endtask

	// watchdog for the whole run
	initial begin
		#(RUN_LIMIT);
		$display("simulation ran past %0d ns without finishing", RUN_LIMIT);
		$display("CHECKS FAILED");
		$finish;
	end

	// main sequence playing the data file
	// --------------------
	initial begin
		int             fd;
		int             code;
		int             fields;
		string          line;
		string          op;
		string          name;
		logic [31:0]    a, b, w, dflt, eline, eexp, dly;
		lease_wb_word_u rd;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		cache_req  = '0;
		cache_addr = '0;
		resetn     = 1'b0;
		repeat (3) @(posedge clock);    // three reset edges
		@(negedge clock);
		resetn = 1'b1;
		check_resp("reset flags", '0, resp);
		check_addr("reset line", '0, addr_out);

		fd = $fopen("testbench/lease_input.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/lease_input.txt");
			other_count++;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && !(line.len() > 0 && line[0] == "#")) begin
					fields = $sscanf(line, "%s %s %h %h %h %h %h %h %d",
					                 op, name, a, b, w, dflt, eline, eexp, dly);
					if (fields > 0 && fields != 9) begin
						$display("badly formed line in data file: %s", line);
						other_count++;
					end else if (fields == 9) begin
						case (op)
							"CFGW":   wb_access(name, 1'b1, {REGION_CONFIG, 6'd0}, a, rd);
							"CFGR": begin
								wb_access(name, 1'b0, {REGION_CONFIG, 6'd0}, '0, rd);
								check_word(name, w, rd);
							end
							"ENTRY":  wb_access(name, 1'b1, {REGION_ENTRY, a[5:0]}, b, rd);
							"REMOVE": wb_access(name, 1'b1, {REGION_REMOVE, a[5:0]}, '0, rd);
							"HIT":    drive_hit(name, a[LINE_W-1:0], b[BW_REF_ADDR-1:0], dflt[0]);
							"MISS":   drive_miss(name, b[BW_REF_ADDR-1:0], eline[LINE_W-1:0],
							                     eexp[0], dly);
							default: begin
								$display("unknown operation %s in data file", op);
								other_count++;
							end
						endcase
					end
				end
			end
			$fclose(fd);
		end

		$display("errors: %0d mismatches, %0d timeouts, %0d other",
		         mismatch_count, timeout_count, other_count);
		if (mismatch_count == 0 && timeout_count == 0 && other_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: testbench/lease_input.txt
# op name a b word dflt line expired delay  (a b word line in hex, delay in decimal)
# a = config word, table index or hit line; b = entry word or access address
CFGR   cfg_reset_read     0         0         00000000  0  0  0  0
CFGW   cfg_write_2        abcd0002  0         00000000  0  0  0  0
CFGR   cfg_read_2         0         0         00000002  0  0  0  0
ENTRY  entry0_write       0         00010005  00000000  0  0  0  0
ENTRY  entry1_write       1         00020003  00000000  0  0  0  0
MISS   fill_line0         0         000100    00000000  0  0  0  1
MISS   fill_line1         0         000200    00000000  0  1  0  1
MISS   fill_line2         0         000300    00000000  0  2  0  1
MISS   fill_line3         0         000400    00000000  0  3  0  1
HIT    hit_l0_entry0      0         000100    00000000  0  0  0  0
HIT    hit_l1_entry1      1         000200    00000000  0  0  0  0
HIT    hit_l2_no_entry    2         000300    00000000  1  0  0  0
HIT    hit_l3_entry0_a    3         000100    00000000  0  0  0  0
HIT    hit_l3_entry0_b    3         000100    00000000  0  0  0  0
MISS   expired_line1      0         000400    00000000  0  1  1  1
REMOVE remove_entry0      0         0         00000000  0  0  0  0
HIT    hit_l1_removed     1         000100    00000000  1  0  0  0
CFGW   cfg_write_16       00000010  0         00000000  0  0  0  0
CFGR   cfg_read_16        0         0         00000010  0  0  0  0
HIT    hit_l0_default     0         000500    00000000  1  0  0  0
HIT    hit_l2_default     2         000500    00000000  1  0  0  0
HIT    hit_l1_default     1         000500    00000000  1  0  0  0
MISS   random_1           0         000600    00000000  0  3  0  2
MISS   random_2           0         000700    00000000  0  3  0  2
MISS   random_3           0         000800    00000000  0  2  0  2

// File: sim.f
hw/lease_pkg.sv
hw/lease_lookup_table.sv
hw/expired_line_encoder.sv
hw/replacement_lfsr.sv
hw/lease_config_wb.sv
hw/lease_policy_controller.sv
hw/lease_cache_policy_top.sv
testbench/lease_policy_tb.sv

// File: Bender.yml
package:
  name: lease_cache_policy

sources:
  - files:
      - hw/lease_pkg.sv
      - hw/lease_lookup_table.sv
      - hw/expired_line_encoder.sv
      - hw/replacement_lfsr.sv
      - hw/lease_config_wb.sv
      - hw/lease_policy_controller.sv
      - hw/lease_cache_policy_top.sv
  - target: test
    files:
      - testbench/lease_policy_tb.sv
